// ==== include/niu_config.svh ====
`ifndef NIU_CONFIG_SVH
`define NIU_CONFIG_SVH

// Datapath and address width
`define NIU_WORD_BITS 32

`define NIU_INSTR_BYTES 4   // PC step per instruction

// Immediate field of the I-form word, sign-extended on the bus
`define NIU_IMM_BITS 17

`define NIU_REG_COUNT 32    // General registers

// Reset value of the program counter
`define NIU_PC_START 32'h0

`endif

// ==== hdl/niuPkg.sv ====
`include "niu_config.svh"

package niuPkg;
    localparam int REG_BITS = $clog2(`NIU_REG_COUNT);
    localparam int OP_BITS = 5;
    localparam int PAD_BITS = `NIU_WORD_BITS - 2 * OP_BITS - 3 * REG_BITS;

    // Primary opcodes, bits 31:27 of every instruction
    typedef enum logic [OP_BITS-1:0] {
        OP_ALUR = 5'b00000,   // Register form, function in op2
        OP_ADDI = 5'b00001,
        OP_MLTI = 5'b00010,
        OP_ANDI = 5'b00101,
        OP_ORI  = 5'b00110,
        OP_XORI = 5'b00111,
        OP_SULI = 5'b01000,
        OP_SSLI = 5'b01001,
        OP_SURI = 5'b01010,
        OP_SSRI = 5'b01011,
        OP_LW   = 5'b10000,
        OP_SW   = 5'b10011,
        OP_BEQ  = 5'b11000,
        OP_BNE  = 5'b11001,
        OP_BLT  = 5'b11010,
        OP_BLE  = 5'b11011,
        OP_JAL  = 5'b11111
    } op1T;

    // Immediate opcodes reuse these codes directly
    typedef enum logic [OP_BITS-1:0] {
        FN_SUB = 5'b00000,
        FN_ADD = 5'b00001,
        FN_MLT = 5'b00010,
        FN_NOT = 5'b00100,
        FN_AND = 5'b00101,
        FN_OR  = 5'b00110,
        FN_XOR = 5'b00111,
        FN_SUL = 5'b01000,
        FN_SSL = 5'b01001,
        FN_SUR = 5'b01010,
        FN_SSR = 5'b01011,
        FN_EQ  = 5'b10000,   // Compares return 0 or 1
        FN_NEQ = 5'b10001,
        FN_LT  = 5'b10010,
        FN_LEQ = 5'b10011
    } aluFuncT;

    typedef struct packed {
        op1T                 op1;
        logic [REG_BITS-1:0] rx;
        logic [REG_BITS-1:0] ry;
        logic [REG_BITS-1:0] rz;
        logic [PAD_BITS-1:0] unused;
        aluFuncT             op2;
    } instrRegT;

    typedef struct packed {
        op1T                      op1;
        logic [REG_BITS-1:0]      rx;
        logic [REG_BITS-1:0]      ry;
        logic [`NIU_IMM_BITS-1:0] imm;
    } instrImmT;

    // Same IR word seen as register form or immediate form
    typedef union packed {
        instrRegT r;
        instrImmT i;
    } instrT;

    typedef enum logic [2:0] {
        SRC_PC, SRC_REG, SRC_IMM, SRC_IMM4, SRC_ALU, SRC_MDR
    } busSrcT;

    typedef struct packed {
        logic                ldPc;
        logic                incPc;
        logic                ldIr;
        logic                regWrite;
        logic [REG_BITS-1:0] regSel;
        logic                ldA;
        logic                ldB;
        aluFuncT             aluFunc;
        logic                ldMar;
        logic                memWrite;
        busSrcT              busSrc;
    } ctrlT;

    typedef struct packed {
        logic [`NIU_WORD_BITS-1:0] addr;
        logic [`NIU_WORD_BITS-1:0] wdata;
        logic                      write;
    } dataReqT;

    typedef enum logic [4:0] {
        S_IDLE, S_FETCH, S_DECODE,
        S_ALU0, S_ALU1, S_ALU2, S_ALU3,
        S_MEM0, S_MEM1, S_MEM2, S_MEM3, S_LW4, S_LW5, S_SW4,
        S_BR0, S_BR1, S_BR2, S_BR3, S_BR4, S_BR5, S_BR6, S_BR7,
        S_JAL0, S_JAL1, S_HALT
    } stateT;
endpackage

// ==== hdl/niuAlu.sv ====
`timescale 1ns/100ps
`include "niu_config.svh"

module niuAlu (
    input  logic                      clk,
    input  niuPkg::ctrlT              ctrl,
    input  logic [`NIU_WORD_BITS-1:0] bus,
    output logic [`NIU_WORD_BITS-1:0] result
);
    import niuPkg::*;

    localparam int W = `NIU_WORD_BITS;

    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] aluOut;

    always_comb begin
        case (ctrl.aluFunc)
            FN_SUB:  aluOut = a - b;
            FN_ADD:  aluOut = a + b;
            FN_MLT:  aluOut = a * b;  // Low word of the product
            FN_NOT:  aluOut = ~a;
            FN_AND:  aluOut = a & b;
            FN_OR:   aluOut = a | b;
            FN_XOR:  aluOut = a ^ b;
            FN_SUL:  aluOut = a << b;
            FN_SSL:  aluOut = a <<< b;
            FN_SUR:  aluOut = a >> b;
            FN_SSR:  aluOut = $signed(a) >>> b;
            // Signed compares, flag in bit 0
            FN_EQ:   aluOut = W'(a == b);
            FN_NEQ:  aluOut = W'(a != b);
            FN_LT:   aluOut = W'($signed(a) < $signed(b));
            FN_LEQ:  aluOut = W'($signed(a) <= $signed(b));
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.ldA) begin
            a <= bus;
        end
        if (ctrl.ldB) begin
            b <= bus;
        end
        result <= aluOut;  // Valid the cycle after the compute state
    end
endmodule

// ==== hdl/niuFetch.sv ====
`timescale 1ns/100ps
`include "niu_config.svh"

module niuFetch (
    input  logic                      clk,
    input  logic                      reset,
    input  niuPkg::ctrlT              ctrl,
    input  logic [`NIU_WORD_BITS-1:0] bus,
    input  logic [`NIU_WORD_BITS-1:0] fetchData,
    output logic [`NIU_WORD_BITS-1:0] pc,
    output niuPkg::instrT             ir
);
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `NIU_PC_START;
        end else if (ctrl.ldPc) begin
            pc <= bus;  // Branch target or jump register
        end else if (ctrl.incPc) begin
            pc <= pc + `NIU_INSTR_BYTES;
        end
    end

    // Instruction word held for the whole execute sequence
    always_ff @(posedge clk) begin
        if (ctrl.ldIr) begin
            ir <= fetchData;
        end
    end
endmodule

// ==== hdl/niuRegFile.sv ====
`timescale 1ns/100ps
`include "niu_config.svh"

module niuRegFile (
    input  logic                      clk,
    input  logic                      reset,
    input  niuPkg::ctrlT              ctrl,
    input  logic [`NIU_WORD_BITS-1:0] bus,
    output logic [`NIU_WORD_BITS-1:0] rdata
);
    logic [`NIU_WORD_BITS-1:0] regs [`NIU_REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NIU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regs[ctrl.regSel] <= bus;
        end
    end

    // Read and write share one selector
    assign rdata = regs[ctrl.regSel];
endmodule

// ==== hdl/niuMemPort.sv ====
`timescale 1ns/100ps
`include "niu_config.svh"

module niuMemPort (
    input  logic                      clk,
    input  logic                      reset,
    input  niuPkg::ctrlT              ctrl,
    input  logic [`NIU_WORD_BITS-1:0] bus,
    input  logic [`NIU_WORD_BITS-1:0] dataRdata,
    output niuPkg::dataReqT           dataReq,
    output logic [`NIU_WORD_BITS-1:0] mdr
);
    logic [`NIU_WORD_BITS-1:0] mar;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mar <= '0;
        end else if (ctrl.ldMar) begin
            mar <= bus;
        end
    end

    // Read data for the address in MAR, sampled one cycle after MAR loads
    always_ff @(posedge clk) begin
        mdr <= dataRdata;
    end

    // Store data comes straight off the bus
    assign dataReq = '{addr: mar, wdata: bus, write: ctrl.memWrite};
endmodule

// ==== hdl/niuControl.sv ====
`timescale 1ns/100ps

module niuControl (
    input  logic          clk,
    input  logic          reset,
    input  niuPkg::instrT ir,
    input  logic          cmpFlag,
    output niuPkg::ctrlT  ctrl,
    output logic          fetchStrobe,
    output logic          halted
);
    import niuPkg::*;

    stateT state;
    stateT nextState;
    logic  isRegForm;

    // Compare function selected by the branch opcode
    function automatic aluFuncT branchFunc(op1T op);
        case (op)
            OP_BNE:  return FN_NEQ;
            OP_BLT:  return FN_LT;
            OP_BLE:  return FN_LEQ;
            default: return FN_EQ;
        endcase
    endfunction

    assign isRegForm = (ir.r.op1 == OP_ALUR);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        ctrl = '0;
        nextState = state;
        case (state)
            S_IDLE: nextState = S_FETCH;
            S_FETCH: begin
                ctrl.ldIr = 1'b1;
                ctrl.incPc = 1'b1;
                nextState = S_DECODE;
            end
            S_DECODE: begin
                case (ir.r.op1)
                    OP_ALUR, OP_ADDI, OP_MLTI, OP_ANDI, OP_ORI, OP_XORI,
                    OP_SULI, OP_SSLI, OP_SURI, OP_SSRI: nextState = S_ALU0;
                    OP_LW, OP_SW: nextState = S_MEM0;
                    OP_BEQ, OP_BNE, OP_BLT, OP_BLE: nextState = S_BR0;
                    OP_JAL: nextState = S_JAL0;
                    default: nextState = S_HALT;  // Undefined opcode
                endcase
            end
            S_ALU0: begin
                ctrl.regSel = ir.r.ry;
                ctrl.ldB = 1'b1;
                if (isRegForm) begin
                    ctrl.busSrc = SRC_REG;
                end else begin
                    ctrl.busSrc = SRC_IMM;
                end
                nextState = S_ALU1;
            end
            S_ALU1, S_MEM0, S_BR0: begin
                ctrl.regSel = ir.r.rx;  // A operand is always rx
                ctrl.busSrc = SRC_REG;
                ctrl.ldA = 1'b1;
                if (state == S_ALU1) begin
                    nextState = S_ALU2;
                end else if (state == S_MEM0) begin
                    nextState = S_MEM1;
                end else begin
                    nextState = S_BR1;
                end
            end
            S_ALU2: begin
                if (isRegForm) begin
                    ctrl.aluFunc = ir.r.op2;
                end else begin
                    ctrl.aluFunc = aluFuncT'(ir.r.op1);
                end
                nextState = S_ALU3;
            end
            S_ALU3: begin
                ctrl.regSel = isRegForm ? ir.r.rz : ir.r.ry;
                ctrl.busSrc = SRC_ALU;
                ctrl.regWrite = 1'b1;
                nextState = S_FETCH;
            end
            S_MEM1: begin
                ctrl.busSrc = SRC_IMM;
                ctrl.ldB = 1'b1;
                nextState = S_MEM2;
            end
            S_MEM2: begin
                ctrl.aluFunc = FN_ADD;  // Effective address
                nextState = S_MEM3;
            end
            S_MEM3: begin
                ctrl.busSrc = SRC_ALU;
                ctrl.ldMar = 1'b1;
                if (ir.r.op1 == OP_LW) begin
                    nextState = S_LW4;
                end else begin
                    nextState = S_SW4;
                end
            end
            S_LW4: nextState = S_LW5;  // MDR takes the read data
            S_LW5: begin
                ctrl.regSel = ir.r.ry;
                ctrl.busSrc = SRC_MDR;
                ctrl.regWrite = 1'b1;
                nextState = S_FETCH;
            end
            S_SW4: begin
                ctrl.regSel = ir.r.ry;
                ctrl.busSrc = SRC_REG;
                ctrl.memWrite = 1'b1;
                nextState = S_FETCH;
            end
            S_BR1: begin
                ctrl.regSel = ir.r.ry;
                ctrl.busSrc = SRC_REG;
                ctrl.ldB = 1'b1;
                nextState = S_BR2;
            end
            S_BR2: begin
                ctrl.aluFunc = branchFunc(ir.r.op1);
                nextState = S_BR3;
            end
            S_BR3: nextState = cmpFlag ? S_BR4 : S_FETCH;
            S_BR4: begin
                ctrl.busSrc = SRC_PC;  // Already points past the branch
                ctrl.ldA = 1'b1;
                nextState = S_BR5;
            end
            S_BR5: begin
                ctrl.busSrc = SRC_IMM4;
                ctrl.ldB = 1'b1;
                nextState = S_BR6;
            end
            S_BR6: begin
                ctrl.aluFunc = FN_ADD;
                nextState = S_BR7;
            end
            S_BR7: begin
                ctrl.busSrc = SRC_ALU;
                ctrl.ldPc = 1'b1;
                nextState = S_FETCH;
            end
            S_JAL0: begin
                ctrl.regSel = ir.r.ry;  // Link register
                ctrl.busSrc = SRC_PC;
                ctrl.regWrite = 1'b1;
                nextState = S_JAL1;
            end
            S_JAL1: begin
                ctrl.regSel = ir.r.rx;
                ctrl.busSrc = SRC_REG;
                ctrl.ldPc = 1'b1;
                nextState = S_FETCH;
            end
            S_HALT: nextState = S_HALT;
            default: nextState = S_HALT;
        endcase
    end

    assign fetchStrobe = (state == S_FETCH);
    assign halted = (state == S_HALT);
endmodule

// ==== hdl/niuCpu.sv ====
`timescale 1ns/100ps
`include "niu_config.svh"

module niuCpu (
    input  logic                      clk,
    input  logic                      reset,
    output logic [`NIU_WORD_BITS-1:0] fetchAddr,
    output logic                      fetchStrobe,
    input  logic [`NIU_WORD_BITS-1:0] fetchData,
    output niuPkg::dataReqT           dataReq,
    input  logic [`NIU_WORD_BITS-1:0] dataRdata,
    output logic                      halted
);
    import niuPkg::*;

    localparam int IMM_SHIFT = $clog2(`NIU_INSTR_BYTES);

    ctrlT                      ctrl;
    instrT                     ir;
    logic [`NIU_WORD_BITS-1:0] bus;
    logic [`NIU_WORD_BITS-1:0] pc;
    logic [`NIU_WORD_BITS-1:0] rdata;
    logic [`NIU_WORD_BITS-1:0] aluResult;
    logic [`NIU_WORD_BITS-1:0] mdr;
    logic [`NIU_WORD_BITS-1:0] immExt;

    assign immExt = {{(`NIU_WORD_BITS - `NIU_IMM_BITS){ir.i.imm[`NIU_IMM_BITS-1]}}, ir.i.imm};

    // Single internal bus, one source per state
    always_comb begin
        case (ctrl.busSrc)
            SRC_PC:   bus = pc;
            SRC_REG:  bus = rdata;
            SRC_IMM:  bus = immExt;
            SRC_IMM4: bus = immExt << IMM_SHIFT;  // Branch offset in bytes
            SRC_ALU:  bus = aluResult;
            SRC_MDR:  bus = mdr;
            default:  bus = '0;
        endcase
    end

    assign fetchAddr = pc;

    niuControl control0 (
        .clk, .reset, .ir, .cmpFlag(aluResult[0]), .ctrl, .fetchStrobe, .halted
    );

    niuFetch fetch0 (.clk, .reset, .ctrl, .bus, .fetchData, .pc, .ir);

    niuRegFile regFile0 (.clk, .reset, .ctrl, .bus, .rdata);

    niuAlu alu0 (.clk, .ctrl, .bus, .result(aluResult));

    niuMemPort memPort0 (.clk, .reset, .ctrl, .bus, .dataRdata, .dataReq, .mdr);
endmodule

// ==== testbench/niuCpu_properties.sv ====
`timescale 1ns/100ps

module niuCpuProperties (
    input logic clk,
    input logic reset,
    input logic fetchStrobe,
    input logic memWrite,
    input logic halted
);
    int failCount = 0;

    // Fetch and store never share a cycle
    strobeExclusive: assert property (@(posedge clk) disable iff (reset)
        !(fetchStrobe && memWrite))
        else begin
            failCount++;
            $error("fetchStrobe and write high in the same cycle");
        end

    fetchOneCycle: assert property (@(posedge clk) disable iff (reset)
        fetchStrobe |=> !fetchStrobe)
        else begin
            failCount++;
            $error("fetchStrobe high for more than one cycle");
        end

    writeOneCycle: assert property (@(posedge clk) disable iff (reset)
        memWrite |=> !memWrite)
        else begin
            failCount++;
            $error("write high for more than one cycle");
        end

    // Only reset leaves the halt state
    haltSticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else begin
            failCount++;
            $error("halted dropped without reset");
        end
endmodule

// ==== testbench/niuChecker.sv ====
`timescale 1ns/100ps
`include "niu_config.svh"

module niuChecker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`NIU_WORD_BITS-1:0] fetchAddr,
    input  logic                      fetchStrobe,
    input  logic [`NIU_WORD_BITS-1:0] fetchData,
    input  niuPkg::dataReqT           dataReq,
    input  logic                      halted,
    output int                        errorCount,
    output int                        instrCount,
    output int                        storeCount
);
    import niuPkg::*;

    localparam int W = `NIU_WORD_BITS;
    // Cycles from one fetch strobe to the next, per class
    localparam int ALU_GAP = 6;
    localparam int LW_GAP = 8;
    localparam int SW_GAP = 7;
    localparam int BR_GAP = 6;
    localparam int BR_TAKEN_GAP = 10;
    localparam int JAL_GAP = 4;
    localparam int SW_SLOT = 6;     // Write cycle counted from the SW fetch
    localparam int HALT_DELAY = 2;
    localparam int GAP_LIMIT = 12;

    logic [W-1:0] regs [`NIU_REG_COUNT];
    logic [W-1:0] dmem [logic [W-1:0]];
    logic [W-1:0] storeAddrQ [$];
    logic [W-1:0] storeDataQ [$];
    logic [W-1:0] modelPc;
    int           gap;
    int           expectGap;
    int           storeSlot;
    bit           started;
    bit           expectHalt;
    bit           haltSeen;

    // Unwritten data words, same rule as the data memory
    function automatic logic [W-1:0] fillWord(logic [W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b3d_91c5;
    endfunction

    function automatic logic [W-1:0] aluModel(aluFuncT fn, logic [W-1:0] a, logic [W-1:0] b);
        case (fn)
            FN_SUB: return a - b;
            FN_ADD: return a + b;
            FN_MLT: return a * b;
            FN_NOT: return ~a;
            FN_AND: return a & b;
            FN_OR:  return a | b;
            FN_XOR: return a ^ b;
            FN_SUL, FN_SSL: return (b >= W) ? '0 : (a << b[4:0]);
            FN_SUR: return (b >= W) ? '0 : (a >> b[4:0]);
            FN_SSR: begin
                if (b >= W) begin
                    return {W{a[W-1]}};
                end else begin
                    return $signed(a) >>> b[4:0];
                end
            end
            default: return '0;
        endcase
    endfunction

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("Check failed: %s", msg);
    endtask

    task automatic clearModel();
        for (int i = 0; i < `NIU_REG_COUNT; i++) begin
            regs[i] = '0;
        end
        dmem.delete();
        storeAddrQ.delete();
        storeDataQ.delete();
        modelPc = `NIU_PC_START;
        gap = 0;
        expectGap = 0;
        storeSlot = -1;
        started = 1'b0;
        expectHalt = 1'b0;
        haltSeen = 1'b0;
    endtask

    // Instruction-set model, one whole instruction per fetch
    task automatic execute(input logic [W-1:0] word);
        instrT        iw;
        logic [W-1:0] x;
        logic [W-1:0] y;
        logic [W-1:0] imm;
        logic [W-1:0] nextPc;
        logic [W-1:0] addr;
        bit           taken;
        iw = word;
        x = regs[iw.r.rx];
        y = regs[iw.r.ry];
        imm = {{(W - `NIU_IMM_BITS){iw.i.imm[`NIU_IMM_BITS-1]}}, iw.i.imm};
        nextPc = modelPc + `NIU_INSTR_BYTES;
        modelPc = nextPc;
        storeSlot = -1;
        case (iw.r.op1)
            OP_ALUR: begin
                regs[iw.r.rz] = aluModel(iw.r.op2, x, y);
                expectGap = ALU_GAP;
            end
            OP_ADDI, OP_MLTI, OP_ANDI, OP_ORI, OP_XORI,
            OP_SULI, OP_SSLI, OP_SURI, OP_SSRI: begin
                regs[iw.i.ry] = aluModel(aluFuncT'(iw.i.op1), x, imm);
                expectGap = ALU_GAP;
            end
            OP_LW: begin
                addr = x + imm;
                regs[iw.i.ry] = dmem.exists(addr) ? dmem[addr] : fillWord(addr);
                expectGap = LW_GAP;
            end
            OP_SW: begin
                addr = x + imm;
                dmem[addr] = y;
                storeAddrQ.push_back(addr);
                storeDataQ.push_back(y);
                storeSlot = SW_SLOT;
                expectGap = SW_GAP;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BLE: begin
                case (iw.i.op1)
                    OP_BEQ:  taken = (x == y);
                    OP_BNE:  taken = (x != y);
                    OP_BLT:  taken = ($signed(x) < $signed(y));
                    default: taken = ($signed(x) <= $signed(y));
                endcase
                if (taken) begin
                    modelPc = nextPc + imm * `NIU_INSTR_BYTES;
                end
                expectGap = taken ? BR_TAKEN_GAP : BR_GAP;
            end
            OP_JAL: begin
                regs[iw.i.ry] = nextPc;
                modelPc = regs[iw.i.rx];  // Link written first
                expectGap = JAL_GAP;
            end
            default: expectHalt = 1'b1;
        endcase
    endtask

    task automatic takeFetch();
        if (started && gap != expectGap) begin
            errorCount++;
            $display("ERR fetchStrobe gap: expected %h, got %h", expectGap, gap);
        end
        if (fetchAddr !== modelPc) begin
            errorCount++;
            $display("ERR fetchAddr: expected %h, got %h", modelPc, fetchAddr);
        end
        // The store of an SW lands before the next fetch
        if (storeAddrQ.size() != 0) begin
            reportFailure("an SW ended without its write strobe");
            storeAddrQ.delete();
            storeDataQ.delete();
        end
        execute(fetchData);
        instrCount++;
        gap = 0;
        started = 1'b1;
    endtask

    task automatic checkStore();
        logic [W-1:0] expAddr;
        logic [W-1:0] expData;
        if (gap != storeSlot || storeAddrQ.size() == 0) begin
            reportFailure("write strobe outside the store cycle of an SW");
        end else begin
            expAddr = storeAddrQ.pop_front();
            expData = storeDataQ.pop_front();
            storeCount++;
            if (dataReq.addr !== expAddr) begin
                errorCount++;
                $display("ERR dataReq.addr: expected %h, got %h", expAddr, dataReq.addr);
            end
            if (dataReq.wdata !== expData) begin
                errorCount++;
                $display("ERR dataReq.wdata: expected %h, got %h", expData, dataReq.wdata);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (fetchStrobe === 1'b1 || dataReq.write === 1'b1 || halted === 1'b1) begin
                reportFailure("output active while reset is high");
            end
            clearModel();
        end else begin
            if (started) begin
                gap++;
            end
            if (dataReq.write) begin
                checkStore();
            end
            if (halted && !expectHalt && !haltSeen) begin
                reportFailure("halted rose without an illegal opcode");
                haltSeen = 1'b1;
            end
            if (expectHalt && gap == HALT_DELAY && !halted) begin
                reportFailure("halted did not rise after an illegal opcode");
            end
            if (fetchStrobe) begin
                if (expectHalt) begin
                    reportFailure("fetch strobe after an illegal opcode");
                end else begin
                    takeFetch();
                end
            end else if (started && !expectHalt && gap == GAP_LIMIT) begin
                reportFailure("no fetch strobe within the longest instruction time");
            end
        end
    end
endmodule

// ==== testbench/niuCpuTb.sv ====
`timescale 1ns/100ps
`include "niu_config.svh"

module niuCpuTb;
    import niuPkg::*;

    localparam int W = `NIU_WORD_BITS;
    localparam int PROG_WORDS = 256;
    localparam int HALT_TIMEOUT = 20000;
    localparam int QUIET_CYCLES = 20;
    localparam int ZERO_REG = 31;   // Never a destination, stays zero
    localparam int JUMP_REG = 30;   // Written only by the ADDI before a JAL
    localparam logic [W-1:0] ILLEGAL_WORD = 32'h7800_0000;
    localparam op1T IMM_OPS [9] = '{OP_ADDI, OP_MLTI, OP_ANDI, OP_ORI, OP_XORI,
                                    OP_SULI, OP_SSLI, OP_SURI, OP_SSRI};
    localparam aluFuncT REG_FUNCS [11] = '{FN_SUB, FN_ADD, FN_MLT, FN_NOT, FN_AND, FN_OR,
                                          FN_XOR, FN_SUL, FN_SSL, FN_SUR, FN_SSR};
    localparam op1T BR_OPS [4] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BLE};

    logic         clk;
    logic         reset;
    logic [W-1:0] fetchAddr;
    logic         fetchStrobe;
    logic [W-1:0] fetchData;
    dataReqT      dataReq;
    logic [W-1:0] dataRdata;
    logic         halted;
    int           errorCount;
    int           instrCount;
    int           storeCount;
    bit           timedOut;

    logic [W-1:0] imem [0:PROG_WORDS];
    logic [W-1:0] dmem [logic [W-1:0]];
    bit           noJal [0:PROG_WORDS];  // Slots reached by a jump or branch

    niuCpu dut0 (
        .clk(clk), .reset(reset), .fetchAddr(fetchAddr), .fetchStrobe(fetchStrobe),
        .fetchData(fetchData), .dataReq(dataReq), .dataRdata(dataRdata), .halted(halted)
    );

    niuChecker checker0 (
        .clk(clk), .reset(reset), .fetchAddr(fetchAddr), .fetchStrobe(fetchStrobe),
        .fetchData(fetchData), .dataReq(dataReq), .halted(halted),
        .errorCount(errorCount), .instrCount(instrCount), .storeCount(storeCount)
    );

    bind niuControl niuCpuProperties props0 (
        .clk(clk), .reset(reset), .fetchStrobe(fetchStrobe),
        .memWrite(ctrl.memWrite), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [W-1:0] fillWord(logic [W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b3d_91c5;
    endfunction

    function automatic logic [W-1:0] fetchWord(logic [W-1:0] addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) <= PROG_WORDS) begin
            return imem[addr >> 2];
        end else begin
            return ILLEGAL_WORD;
        end
    endfunction

    // Instruction and data memories, answers 1 ns after the edge
    always @(posedge clk) begin
        if (dataReq.write) begin
            dmem[dataReq.addr] = dataReq.wdata;
        end
        #1;
        fetchData <= fetchWord(fetchAddr);
        dataRdata <= dmem.exists(dataReq.addr) ? dmem[dataReq.addr] : fillWord(dataReq.addr);
    end

    function automatic int pickDest();
        return $urandom_range(0, 29);
    endfunction

    function automatic logic [W-1:0] regWord(aluFuncT fn, int rx, int ry, int rz);
        instrT w;
        w.r.op1 = OP_ALUR;
        w.r.rx = REG_BITS'(rx);
        w.r.ry = REG_BITS'(ry);
        w.r.rz = REG_BITS'(rz);
        w.r.unused = PAD_BITS'($urandom());
        w.r.op2 = fn;
        return w;
    endfunction

    function automatic logic [W-1:0] immWord(op1T op, int rx, int ry, int imm);
        instrT w;
        w.i.op1 = op;
        w.i.rx = REG_BITS'(rx);
        w.i.ry = REG_BITS'(ry);
        w.i.imm = imm[`NIU_IMM_BITS-1:0];
        return w;
    endfunction

    task automatic makeInstr(input int idx, output logic [W-1:0] word);
        int  kind;
        int  rx;
        int  off;
        op1T op;
        kind = $urandom_range(0, 99);
        rx = ($urandom_range(0, 3) == 0) ? ZERO_REG : $urandom_range(0, 31);
        if (kind < 30) begin
            word = regWord(REG_FUNCS[$urandom_range(0, 10)], rx, $urandom_range(0, 31),
                           pickDest());
        end else if (kind < 60) begin
            op = IMM_OPS[$urandom_range(0, 8)];
            if (op inside {OP_SULI, OP_SSLI, OP_SURI, OP_SSRI}) begin
                word = immWord(op, rx, pickDest(), $urandom_range(0, 33));
            end else begin
                word = immWord(op, rx, pickDest(), $urandom());
            end
        end else if (kind < 70) begin
            word = immWord(OP_LW, rx, pickDest(), $urandom_range(0, 15) * 4);
        end else if (kind < 80) begin
            word = immWord(OP_SW, rx, $urandom_range(0, 31), $urandom_range(0, 15) * 4);
        end else begin
            off = $urandom_range(0, 3);  // Forward only, so the run ends
            if (idx + 1 + off > PROG_WORDS) begin
                off = PROG_WORDS - idx - 1;
            end
            noJal[idx + 1 + off] = 1'b1;
            word = immWord(BR_OPS[$urandom_range(0, 3)], rx, $urandom_range(0, 31), off);
        end
    endtask

    task automatic buildProgram();
        int idx;
        int target;
        int top;
        for (idx = 0; idx <= PROG_WORDS; idx++) begin
            noJal[idx] = 1'b0;
        end
        idx = 0;
        while (idx < PROG_WORDS) begin
            if ($urandom_range(0, 99) < 10 && idx + 1 < PROG_WORDS && !noJal[idx + 1]) begin
                top = (idx + 9 < PROG_WORDS) ? idx + 9 : PROG_WORDS;
                target = $urandom_range(idx + 2, top);
                noJal[target] = 1'b1;
                imem[idx] = immWord(OP_ADDI, ZERO_REG, JUMP_REG, target * `NIU_INSTR_BYTES);
                imem[idx + 1] = immWord(OP_JAL, JUMP_REG, pickDest(), $urandom());
                idx += 2;
            end else begin
                makeInstr(idx, imem[idx]);
                idx++;
            end
        end
        imem[PROG_WORDS] = ILLEGAL_WORD;  // Program falls through into the halt
    endtask

    initial begin : mainFlow
        int waitCycles;
        int assertFails;
        void'($urandom(32'hce993012));
        reset = 1'b1;
        fetchData = '0;
        dataRdata = '0;
        buildProgram();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        waitCycles = 0;
        while (halted !== 1'b1 && waitCycles < HALT_TIMEOUT) begin
            @(posedge clk);
            waitCycles++;
        end
        timedOut = (halted !== 1'b1);
        if (!timedOut) begin
            repeat (QUIET_CYCLES) @(posedge clk);  // No fetch may follow the halt
        end
        assertFails = dut0.control0.props0.failCount;
        $display("Run summary: %0d instructions, %0d stores, %0d check errors, %0d assertion failures",
                 instrCount, storeCount, errorCount, assertFails);
        if (!timedOut && errorCount == 0 && assertFails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            if (timedOut) begin
                $display("Timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
            end
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule

// ==== niuCpu.f ====
+incdir+include
hdl/niuPkg.sv
hdl/niuAlu.sv
hdl/niuFetch.sv
hdl/niuRegFile.sv
hdl/niuMemPort.sv
hdl/niuControl.sv
hdl/niuCpu.sv
testbench/niuCpu_properties.sv
testbench/niuChecker.sv
testbench/niuCpuTb.sv

// ==== Bender.yml ====
package:
  name: niuCpu

export_include_dirs:
  - include

sources:
  - hdl/niuPkg.sv
  - hdl/niuAlu.sv
  - hdl/niuFetch.sv
  - hdl/niuRegFile.sv
  - hdl/niuMemPort.sv
  - hdl/niuControl.sv
  - hdl/niuCpu.sv
  - target: test
    files:
      - testbench/niuCpu_properties.sv
      - testbench/niuChecker.sv
      - testbench/niuCpuTb.sv
